/* Bender.yml */
package:
  name: pma_frontend

sources:
  - include_dirs:
      - src
    files:
      - src/pma_pkg.sv
      - src/pma_reset_sync.sv
      - src/pma_reset_sequencer.sv
      - src/pma_rx_status_align.sv
      - src/pma_frontend_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/pma_frontend_checker.sv
      - sim/tb_pma_frontend.sv

/* sim/pma_frontend_checker.sv */
/*
  Concurrent assertions on the PMA front end, attached to the top level
  with bind. Covers reset release ordering and a quiet receive bus while
  the RX digital reset is held.
*/

`include "pma_config.svh"

module pma_frontend_checker (
  input logic                     clk,
  input logic                     gxb_pwrdn_in,
  input pma_pkg::pma_reset_ctrl_t reset_ctrl,
  input pma_pkg::pma_rx_pcs_t     rx_pcs,
  input logic                     led_link
);

  timeunit 1ns;
  timeprecision 100ps;

  import pma_pkg::*;

  // ----------------------------------------------------------------------
  // Reset ordering
  // ----------------------------------------------------------------------

  // TX digital stays held while the PLL is powered down
  a_tx_after_pll: assert property (@(posedge clk) disable iff (gxb_pwrdn_in)
    reset_ctrl.pll_powerdown |-> reset_ctrl.tx_digitalreset)
    else $error("tx_digitalreset released while pll_powerdown is high");

  // RX digital stays held while RX analog is held
  a_rxd_after_rxa: assert property (@(posedge clk) disable iff (gxb_pwrdn_in)
    reset_ctrl.rx_analogreset |-> reset_ctrl.rx_digitalreset)
    else $error("rx_digitalreset released while rx_analogreset is high");

  // ----------------------------------------------------------------------
  // Output quiescence
  // ----------------------------------------------------------------------

  // RX reset reaches the aligner at once
  a_rx_quiet: assert property (@(posedge clk) disable iff (gxb_pwrdn_in)
    reset_ctrl.rx_digitalreset |-> (rx_pcs == '0) && !led_link)
    else $error("receive outputs active while rx_digitalreset is high");

endmodule

/* sim/tb_pma_frontend.sv */
/*
  Directed testbench for the PMA front end. Models PLL and CDR lock and
  the parallel receive bus, walks the reset sequence, the lock filter,
  receive alignment, error masking and loss of lock.
*/

`include "pma_config.svh"

module tb_pma_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  import pma_pkg::*;

  localparam int TIMEOUT = 200; // Cycles per wait loop

  logic            clk;
  logic            gxb_pwrdn_in;
  logic            reset;
  logic            pll_locked;
  logic            reconfig_busy;
  logic            rx_freqlocked;
  pma_rx_raw_t     rx_raw;
  pma_reset_ctrl_t reset_ctrl;
  logic            tx_ready;
  logic            rx_ready;
  pma_rx_pcs_t     rx_pcs;
  logic            led_link;
  logic            led_char_err;
  logic            led_disp_err;
  logic [31:0]     rng_state;   // xorshift state

  pma_frontend_top u_pma_frontend_top (.*);

  bind pma_frontend_top pma_frontend_checker u_checker (
    .clk          (clk),
    .gxb_pwrdn_in (gxb_pwrdn_in),
    .reset_ctrl   (reset_ctrl),
    .rx_pcs       (rx_pcs),
    .led_link     (led_link)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  // ----------------------------------------------------------------------
  // Helpers and compare tasks
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_value(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out at %0t ns waiting for %s", $time, what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_ctrl(input pma_reset_ctrl_t got, input pma_reset_ctrl_t exp,
                            input string what);
    if (got !== exp)
      fail_value($sformatf("%s reset_ctrl got %b expected %b", what, got, exp));
  endtask

  task automatic check_pcs(input pma_rx_pcs_t got, input pma_rx_pcs_t exp,
                           input string what);
    if (got !== exp)
      fail_value($sformatf("%s rx_pcs got %h expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_value($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic test_reset_state();
    int n;
    repeat (3) begin
      @(negedge clk);
      check_ctrl(reset_ctrl, 4'b1111, "in powerdown");
      check_bit(tx_ready, 1'b0, "tx_ready in powerdown");
      check_bit(rx_ready, 1'b0, "rx_ready in powerdown");
      @(posedge clk);
    end
    gxb_pwrdn_in <= 1'b0;
    n = 0;
    @(negedge clk);
    while (reset_ctrl.pll_powerdown) begin // Count the hold
      check_ctrl(reset_ctrl, 4'b1111, "PLL hold");
      n++;
      if (n > TIMEOUT) fail_timeout("pll_powerdown release");
      @(negedge clk);
    end
    // User reset release, then the PLL hold
    if (n != `PMA_SYNC_DEPTH + `PMA_PLL_PWRDN_CYCLES)
      fail_value($sformatf("pll_powerdown held %0d cycles, expected %0d", n,
                           `PMA_SYNC_DEPTH + `PMA_PLL_PWRDN_CYCLES));
  endtask

  task automatic test_ordered_release();
    int n;
    repeat (10) begin // No lock, no TX
      @(negedge clk);
      check_bit(tx_ready, 1'b0, "tx_ready without PLL lock");
      check_ctrl(reset_ctrl, 4'b0111, "waiting for PLL");
    end
    @(posedge clk);
    pll_locked <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!tx_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("tx_ready");
      @(negedge clk);
    end
    repeat (8) begin // Busy keeps RX analog held
      check_ctrl(reset_ctrl, 4'b0011, "reconfig busy");
      @(negedge clk);
    end
    @(posedge clk);
    reconfig_busy <= 1'b0;
    n = 0;
    @(negedge clk);
    while (reset_ctrl.rx_analogreset) begin
      n++;
      if (n > TIMEOUT) fail_timeout("rx_analogreset release");
      @(negedge clk);
    end
    check_ctrl(reset_ctrl, 4'b0001, "waiting for RX lock");
  endtask

  task automatic test_lock_filter();
    repeat (6) begin
      repeat (`PMA_RX_LOCK_CYCLES - 1) begin // Run one short of the filter
        @(posedge clk);
        rx_freqlocked <= 1'b1;
      end
      @(posedge clk);
      rx_freqlocked <= 1'b0;
      @(negedge clk);
      check_bit(rx_ready, 1'b0, "rx_ready on short lock runs");
    end
    repeat (3) begin
      @(negedge clk);
      check_bit(rx_ready, 1'b0, "rx_ready after short runs");
    end
  endtask

  task automatic test_rx_ready();
    int n;
    @(posedge clk);
    rx_freqlocked <= 1'b1;
    rx_raw.sync   <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!rx_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("rx_ready");
      @(negedge clk);
    end
    check_ctrl(reset_ctrl, 4'b0000, "all released");
    check_bit(tx_ready, 1'b1, "tx_ready with rx_ready");
    n = 0;
    while (!led_link) begin // Waits out the RX synchronizer
      n++;
      if (n > TIMEOUT) fail_timeout("led_link");
      @(negedge clk);
    end
  endtask

  // Random stream, each byte checked one cycle after it is driven
  task automatic stream_raw(input int count, input logic sync_val, input logic err_val,
                            input string what);
    pma_rx_raw_t sent;
    pma_rx_raw_t prev;
    pma_rx_pcs_t exp;
    for (int i = 0; i <= count; i++) begin
      rng_state = xorshift32(rng_state);
      sent.data     = rng_state[7:0];
      sent.kchar    = rng_state[8];
      sent.disp_err = err_val | rng_state[9];
      sent.char_err = err_val | rng_state[10];
      sent.sync     = sync_val;
      @(posedge clk);
      rx_raw <= sent;
      @(negedge clk);
      if (i > 0) begin
        exp.data     = prev.data;
        exp.kchar    = prev.kchar;
        exp.disp_err = prev.sync ? prev.disp_err : 1'b0; // Masked out of sync
        exp.char_err = prev.sync ? prev.char_err : 1'b0;
        check_pcs(rx_pcs, exp, what);
        check_bit(led_link, prev.sync, {what, " led_link"});
        check_bit(led_char_err, exp.char_err, {what, " led_char_err"});
        check_bit(led_disp_err, exp.disp_err, {what, " led_disp_err"});
      end
      prev = sent;
    end
  endtask

  task automatic test_loss_of_lock();
    int n;
    @(posedge clk);
    pll_locked <= 1'b0;
    n = 0;
    @(negedge clk);
    while (tx_ready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("tx_ready drop");
      @(negedge clk);
    end
    check_bit(rx_ready, 1'b0, "rx_ready after PLL loss");
    check_ctrl(reset_ctrl, 4'b0111, "after PLL loss");
    @(posedge clk);
    reset <= 1'b1; // User reset pulse
    @(posedge clk);
    reset <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!reset_ctrl.pll_powerdown) begin
      n++;
      if (n > TIMEOUT) fail_timeout("pll_powerdown after user reset");
      @(negedge clk);
    end
    check_ctrl(reset_ctrl, 4'b1111, "after user reset");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    gxb_pwrdn_in  = 1'b1;
    reset         = 1'b0;
    pll_locked    = 1'b0;
    reconfig_busy = 1'b1;
    rx_freqlocked = 1'b0;
    rx_raw        = '0;
    rng_state     = 32'h2696;

    test_reset_state();
    test_ordered_release();
    test_lock_filter();
    test_rx_ready();
    stream_raw(40, 1'b1, 1'b0, "aligned stream");
    stream_raw(20, 1'b0, 1'b1, "out of sync");
    stream_raw(20, 1'b1, 1'b1, "errors in sync");
    test_loss_of_lock();

    $display("Done: no errors");
    $finish;
  end

endmodule

/* src/pma_config.svh */
/*
  Build-time constants for the PMA reset and receive-status front end.
  Included by the package, the sequencer, the top level and the testbench.
*/

`ifndef PMA_CONFIG_SVH
`define PMA_CONFIG_SVH

// ----------------------------------------------------------------------
// Reset sequencer timing
// ----------------------------------------------------------------------

`define PMA_PLL_PWRDN_CYCLES 8 // PLL powerdown hold after user reset
`define PMA_RX_LOCK_CYCLES   4 // Consecutive rx_freqlocked cycles needed

// Hold counter width, must cover both values above
`define PMA_CNT_W            4

// ----------------------------------------------------------------------
// Reset synchronizers
// ----------------------------------------------------------------------

`define PMA_SYNC_DEPTH       3 // Flops per synchronizer chain

`endif

/* src/pma_frontend_top.sv */
/*
  PMA reset and receive-status front end. Synchronizes the user reset,
  sequences the transceiver resets and aligns the receive bus. Everything
  runs on clk, gxb_pwrdn_in is the asynchronous reset.
*/

`include "pma_config.svh"

module pma_frontend_top (
  input  logic                     clk,
  input  logic                     gxb_pwrdn_in,
  input  logic                     reset,         // User reset, async
  input  logic                     pll_locked,
  input  logic                     reconfig_busy,
  input  logic                     rx_freqlocked,
  input  pma_pkg::pma_rx_raw_t     rx_raw,
  output pma_pkg::pma_reset_ctrl_t reset_ctrl,
  output logic                     tx_ready,
  output logic                     rx_ready,
  output pma_pkg::pma_rx_pcs_t     rx_pcs,
  output logic                     led_link,
  output logic                     led_char_err,
  output logic                     led_disp_err
);

  logic user_reset_sync; // User reset, released on clk
  logic rx_reset;        // RX digital reset, released on clk

  // ----------------------------------------------------------------------
  // Reset synchronizers
  // ----------------------------------------------------------------------

  // Powerdown also holds the user reset chain
  pma_reset_sync #(.DEPTH(`PMA_SYNC_DEPTH)) u_user_sync (
    .clk       (clk),
    .reset_in  (reset | gxb_pwrdn_in),
    .reset_out (user_reset_sync)
  );

  pma_reset_sync #(.DEPTH(`PMA_SYNC_DEPTH)) u_rx_sync (
    .clk       (clk),
    .reset_in  (reset_ctrl.rx_digitalreset),
    .reset_out (rx_reset)
  );

  // ----------------------------------------------------------------------
  // Reset sequencer and receive aligner
  // ----------------------------------------------------------------------

  pma_reset_sequencer u_seq (
    .clk             (clk),
    .gxb_pwrdn_in    (gxb_pwrdn_in),
    .user_reset_sync (user_reset_sync),
    .pll_locked      (pll_locked),
    .reconfig_busy   (reconfig_busy),
    .rx_freqlocked   (rx_freqlocked),
    .reset_ctrl      (reset_ctrl),
    .tx_ready        (tx_ready),
    .rx_ready        (rx_ready)
  );

  pma_rx_status_align u_align (
    .clk          (clk),
    .rx_reset     (rx_reset),
    .rx_raw       (rx_raw),
    .rx_pcs       (rx_pcs),
    .led_link     (led_link),
    .led_char_err (led_char_err),
    .led_disp_err (led_disp_err)
  );

endmodule

/* src/pma_pkg.sv */
/*
  Shared types for the PMA front end: byte and counter widths, the
  sequencer state encoding, and the packed reset and receive structs.
*/

`include "pma_config.svh"

package pma_pkg;

  // Widths with a meaning
  typedef logic [7:0]            pma_byte_t; // One 8b code-group byte
  typedef logic [`PMA_CNT_W-1:0] pma_cnt_t;  // Sequencer hold counter

  // Reset sequencer states, in release order
  typedef enum logic [2:0] {
    SEQ_PLL_PWRDN    = 3'd0, // Everything held, PLL powered down
    SEQ_WAIT_PLL     = 3'd1, // PLL up, waiting for lock
    SEQ_RX_ANALOG    = 3'd2, // TX running, RX analog held
    SEQ_WAIT_RX_LOCK = 3'd3, // Filtering rx_freqlocked
    SEQ_RX_RUN       = 3'd4  // All resets released
  } pma_seq_state_t;

  // Reset lines toward the transceiver, all active high
  typedef struct packed {
    logic pll_powerdown;
    logic tx_digitalreset;
    logic rx_analogreset;
    logic rx_digitalreset;
  } pma_reset_ctrl_t;

  // Receive bus as it leaves the transceiver
  typedef struct packed {
    pma_byte_t data;
    logic      kchar;    // Control character flag
    logic      disp_err; // Running disparity error
    logic      char_err; // Invalid code group
    logic      sync;     // Word aligner in sync
  } pma_rx_raw_t;

  // Aligned receive bus toward the PCS
  typedef struct packed {
    pma_byte_t data;
    logic      kchar;
    logic      disp_err;
    logic      char_err;
  } pma_rx_pcs_t;

endpackage

/* src/pma_reset_sequencer.sv */
/*
  Transceiver reset sequencer. Releases PLL powerdown, TX digital reset,
  RX analog reset and RX digital reset in that order, gated by PLL lock,
  reconfiguration busy and a filtered RX frequency lock. Falls back to an
  earlier state on loss of lock. All outputs are registered.
*/

`include "pma_config.svh"

module pma_reset_sequencer (
  input  logic                     clk,
  input  logic                     gxb_pwrdn_in,
  input  logic                     user_reset_sync,
  input  logic                     pll_locked,
  input  logic                     reconfig_busy,
  input  logic                     rx_freqlocked,
  output pma_pkg::pma_reset_ctrl_t reset_ctrl,
  output logic                     tx_ready,
  output logic                     rx_ready
);

  import pma_pkg::*;

  // Last count value of each hold period
  localparam pma_cnt_t PLL_LAST  = pma_cnt_t'(`PMA_PLL_PWRDN_CYCLES - 1);
  localparam pma_cnt_t LOCK_LAST = pma_cnt_t'(`PMA_RX_LOCK_CYCLES - 1);

  pma_seq_state_t  state;
  pma_seq_state_t  state_nxt;
  pma_cnt_t        cnt;       // Hold / filter counter
  pma_cnt_t        cnt_nxt;
  logic            pll_ok;    // Lock, ignored during user reset
  logic            pll_up;    // State relies on PLL lock
  pma_reset_ctrl_t ctrl_nxt;
  logic            tx_ready_nxt;
  logic            rx_ready_nxt;

  // User reset masks the lock indication
  assign pll_ok = pll_locked & ~user_reset_sync;

  // States past SEQ_WAIT_PLL
  assign pll_up = (state == SEQ_RX_ANALOG) ||
                  (state == SEQ_WAIT_RX_LOCK) ||
                  (state == SEQ_RX_RUN);

  // ----------------------------------------------------------------------
  // Next state and counter
  // ----------------------------------------------------------------------

  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;

    case (state)
      SEQ_PLL_PWRDN: begin
        // Counted only while user reset is low, see override below
        if (cnt == PLL_LAST) begin
          state_nxt = SEQ_WAIT_PLL;
          cnt_nxt   = '0;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end

      SEQ_WAIT_PLL: begin
        if (pll_ok) begin
          state_nxt = SEQ_RX_ANALOG; // Releases TX digital
        end
      end

      SEQ_RX_ANALOG: begin
        if (!reconfig_busy) begin
          state_nxt = SEQ_WAIT_RX_LOCK;
          cnt_nxt   = '0;
        end
      end

      SEQ_WAIT_RX_LOCK: begin
        if (!rx_freqlocked) begin
          cnt_nxt = '0; // Glitch restarts the filter
        end else if (cnt == LOCK_LAST) begin
          state_nxt = SEQ_RX_RUN;
          cnt_nxt   = '0;
        end else begin
          cnt_nxt = cnt + 1'b1;
        end
      end

      SEQ_RX_RUN: begin
        if (!rx_freqlocked) begin
          state_nxt = SEQ_WAIT_RX_LOCK; // Lost CDR lock
          cnt_nxt   = '0;
        end
      end

      default: begin
        state_nxt = SEQ_PLL_PWRDN; // Illegal encoding recovery
        cnt_nxt   = '0;
      end
    endcase

    // PLL lost after release, back to waiting for lock
    if (pll_up && !pll_ok) begin
      state_nxt = SEQ_WAIT_PLL;
      cnt_nxt   = '0;
    end

    // User reset wins over everything
    if (user_reset_sync) begin
      state_nxt = SEQ_PLL_PWRDN;
      cnt_nxt   = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Output decode from next state
  // ----------------------------------------------------------------------

  always_comb begin
    ctrl_nxt     = '1; // All held by default
    tx_ready_nxt = 1'b0;
    rx_ready_nxt = 1'b0;

    case (state_nxt)
      SEQ_WAIT_PLL: begin
        ctrl_nxt.pll_powerdown = 1'b0;
      end
      SEQ_RX_ANALOG: begin
        ctrl_nxt.pll_powerdown   = 1'b0;
        ctrl_nxt.tx_digitalreset = 1'b0;
        tx_ready_nxt             = 1'b1;
      end
      SEQ_WAIT_RX_LOCK: begin
        ctrl_nxt.pll_powerdown   = 1'b0;
        ctrl_nxt.tx_digitalreset = 1'b0;
        ctrl_nxt.rx_analogreset  = 1'b0;
        tx_ready_nxt             = 1'b1;
      end
      SEQ_RX_RUN: begin
        ctrl_nxt     = '0;
        tx_ready_nxt = 1'b1;
        rx_ready_nxt = 1'b1;
      end
      default: begin
        ctrl_nxt = '1; // SEQ_PLL_PWRDN
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // State and output registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or posedge gxb_pwrdn_in) begin
    if (gxb_pwrdn_in) begin
      state      <= SEQ_PLL_PWRDN;
      cnt        <= '0;
      reset_ctrl <= '1;
      tx_ready   <= 1'b0;
      rx_ready   <= 1'b0;
    end else begin
      state      <= state_nxt;
      cnt        <= cnt_nxt;
      reset_ctrl <= ctrl_nxt;     // Tracks state register
      tx_ready   <= tx_ready_nxt;
      rx_ready   <= rx_ready_nxt;
    end
  end

endmodule

/* src/pma_reset_sync.sv */
/*
  Reset synchronizer. Assertion of reset_in reaches reset_out at once,
  release comes out DEPTH clk edges later. Used for the user reset and
  for the RX digital reset under the top level.
*/

module pma_reset_sync #(
  parameter int DEPTH = 2 // Number of flops, 2 or more
) (
  input  logic clk,
  input  logic reset_in,
  output logic reset_out
);

  // ----------------------------------------------------------------------
  // Flop chain, set asynchronously, shifts in zeros
  // ----------------------------------------------------------------------

  logic [DEPTH-1:0] sync_q; // Bit 0 sees the release first

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      sync_q <= '1; // Immediate assertion
    end else begin
      sync_q <= {sync_q[DEPTH-2:0], 1'b0};
    end
  end

  // Last stage drives the synchronized reset
  assign reset_out = sync_q[DEPTH-1];

endmodule

/* src/pma_rx_status_align.sv */
/*
  Receive status aligner. One register stage puts the byte and its flags
  on the same cycle toward the PCS, masks error flags while the word
  aligner is out of sync and drives the link and error LEDs.
*/

module pma_rx_status_align (
  input  logic                 clk,
  input  logic                 rx_reset,
  input  pma_pkg::pma_rx_raw_t rx_raw,
  output pma_pkg::pma_rx_pcs_t rx_pcs,
  output logic                 led_link,
  output logic                 led_char_err,
  output logic                 led_disp_err
);

  import pma_pkg::*;

  pma_rx_pcs_t pcs_d;  // Masked bus, before the register
  pma_rx_pcs_t pcs_q;
  logic        link_q; // Registered sync status

  // ----------------------------------------------------------------------
  // Error masking
  // ----------------------------------------------------------------------

  always_comb begin
    pcs_d.data  = rx_raw.data;
    pcs_d.kchar = rx_raw.kchar;
    // Flags are meaningless before alignment
    pcs_d.disp_err = rx_raw.disp_err & rx_raw.sync;
    pcs_d.char_err = rx_raw.char_err & rx_raw.sync;
  end

  // ----------------------------------------------------------------------
  // Alignment register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or posedge rx_reset) begin
    if (rx_reset) begin
      pcs_q  <= '0; // Quiet bus while RX is held
      link_q <= 1'b0;
    end else begin
      pcs_q  <= pcs_d;
      link_q <= rx_raw.sync;
    end
  end

  assign rx_pcs = pcs_q;

  // LEDs follow the registered flags
  assign led_link     = link_q;
  assign led_char_err = pcs_q.char_err;
  assign led_disp_err = pcs_q.disp_err;

endmodule

/* tb.f */
+incdir+src
src/pma_pkg.sv
src/pma_reset_sync.sv
src/pma_reset_sequencer.sv
src/pma_rx_status_align.sv
src/pma_frontend_top.sv
sim/pma_frontend_checker.sv
sim/tb_pma_frontend.sv
